// ==== logic/lc3b_types.sv ====
package lc3b_types;

    typedef logic [15:0] lc3b_word;

    // pc bits that pick a btb set.
    localparam int btb_index_lo = 2;
    localparam int btb_index_hi = 4;

    // pc bits joined with history to index the counter table.
    localparam int bht_pc_lo = 3;
    localparam int bht_pc_hi = 5;

endpackage : lc3b_types

// ==== logic/bpred_pkg.sv ====
package bpred_pkg;

    import lc3b_types::*;

    localparam int history_bits = 2;
    localparam int btb_sets = 8;
    localparam int btb_ways = 4;
    localparam int bht_entries = 32;

    localparam int btb_set_bits = $clog2(btb_sets);
    localparam int btb_way_bits = $clog2(btb_ways);
    localparam int bht_index_bits = $clog2(bht_entries);

    // upper bit is the predicted direction.
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_t;

    typedef enum logic [1:0] {
        op_none  = 2'b00,
        op_train = 2'b01,
        op_alloc = 2'b10
    } update_op_t;

    typedef struct packed {
        logic     valid;
        lc3b_word pc;
    } lookup_req_t;

    typedef struct packed {
        logic                    valid;
        lc3b_word                pc;
        logic                    hit;
        logic                    taken;
        lc3b_word                target;
        ctr_t                    counter;
        logic [history_bits-1:0] history;
    } prediction_t;

    typedef struct packed {
        logic                    valid;
        lc3b_word                pc;
        logic                    taken;
        lc3b_word                target;
        logic [history_bits-1:0] history;
    } resolve_t;

    typedef struct packed {
        update_op_t              op;
        lc3b_word                pc;
        logic                    taken;
        lc3b_word                target;
        logic [history_bits-1:0] history;
    } table_update_t;

endpackage : bpred_pkg

// ==== logic/bht.sv ====
`timescale 1ns/1ps

module bht
    import bpred_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic [bht_index_bits-1:0] lookup_index,
    output ctr_t                      counter,

    input  logic                      write,
    input  logic [bht_index_bits-1:0] update_index,
    input  logic                      taken
);

    ctr_t ctr_mem [bht_entries];
    ctr_t cur_ctr;
    ctr_t next_ctr;

    // lookup is asynchronous, so a same-cycle write is not visible.
    assign counter = ctr_mem[lookup_index];

    // saturating step toward the resolved direction.
    always_comb begin
        cur_ctr = ctr_mem[update_index];
        next_ctr = cur_ctr;
        if (taken && (cur_ctr != strong_t)) begin
            next_ctr = ctr_t'(cur_ctr + 2'd1);
        end else if (!taken && (cur_ctr != strong_nt)) begin
            next_ctr = ctr_t'(cur_ctr - 2'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < bht_entries; i++) begin
                ctr_mem[i] <= weak_nt;
            end
        end else if (write) begin
            ctr_mem[update_index] <= next_ctr;
        end
    end

endmodule : bht

// ==== logic/btb.sv ====
`timescale 1ns/1ps

module btb
    import lc3b_types::*;
    import bpred_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  lc3b_word lookup_pc,
    output logic     hit,
    output lc3b_word target,

    input  logic     alloc,
    input  lc3b_word alloc_pc,
    input  lc3b_word alloc_target
);

    logic                    valid_mem  [btb_sets][btb_ways];
    lc3b_word                tag_mem    [btb_sets][btb_ways];
    lc3b_word                target_mem [btb_sets][btb_ways];
    logic [btb_way_bits-1:0] rr_ptr     [btb_sets];

    logic [btb_set_bits-1:0] lookup_set;
    logic [btb_set_bits-1:0] alloc_set;

    logic                    match_found;
    logic [btb_way_bits-1:0] match_way;
    logic                    free_found;
    logic [btb_way_bits-1:0] free_way;
    logic [btb_way_bits-1:0] alloc_way;

    assign lookup_set = lookup_pc[btb_index_hi:btb_index_lo];
    assign alloc_set  = alloc_pc[btb_index_hi:btb_index_lo];

    // full pc is the tag, so at most one way matches.
    always_comb begin
        hit = 1'b0;
        target = '0;
        for (int w = 0; w < btb_ways; w++) begin
            if (valid_mem[lookup_set][w] && (tag_mem[lookup_set][w] == lookup_pc)) begin
                hit = 1'b1;
                target = target_mem[lookup_set][w];
            end
        end
    end

    // descending scan leaves the lowest free way selected.
    always_comb begin
        match_found = 1'b0;
        match_way = '0;
        free_found = 1'b0;
        free_way = '0;
        for (int w = btb_ways - 1; w >= 0; w--) begin
            if (valid_mem[alloc_set][w] && (tag_mem[alloc_set][w] == alloc_pc)) begin
                match_found = 1'b1;
                match_way = btb_way_bits'(w);
            end
            if (!valid_mem[alloc_set][w]) begin
                free_found = 1'b1;
                free_way = btb_way_bits'(w);
            end
        end
    end

    always_comb begin
        if (match_found) begin
            alloc_way = match_way;
        end else if (free_found) begin
            alloc_way = free_way;
        end else begin
            alloc_way = rr_ptr[alloc_set];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < btb_sets; s++) begin
                rr_ptr[s] <= '0;
                for (int w = 0; w < btb_ways; w++) begin
                    valid_mem[s][w] <= 1'b0;
                end
            end
        end else if (alloc) begin
            valid_mem[alloc_set][alloc_way] <= 1'b1;
            // pointer only moves when a valid entry is evicted.
            if (!match_found && !free_found) begin
                rr_ptr[alloc_set] <= rr_ptr[alloc_set] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_mem[alloc_set][alloc_way] <= alloc_pc;
            target_mem[alloc_set][alloc_way] <= alloc_target;
        end
    end

endmodule : btb

// ==== logic/branch.sv ====
`timescale 1ns/1ps

module branch
    import lc3b_types::*;
    import bpred_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  lookup_req_t   req,
    input  table_update_t upd,

    output prediction_t   pred
);

    logic [history_bits-1:0]   history;
    logic [bht_index_bits-1:0] lookup_index;
    logic [bht_index_bits-1:0] update_index;

    ctr_t        counter;
    logic        btb_hit;
    lc3b_word    btb_target;
    prediction_t pred_next;

    assign lookup_index = {history, req.pc[bht_pc_hi:bht_pc_lo]};
    assign update_index = {upd.history, upd.pc[bht_pc_hi:bht_pc_lo]};

    bht u_bht (
        .clk,
        .rst_n,
        .lookup_index,
        .counter,
        .write        (upd.op != op_none),
        .update_index,
        .taken        (upd.taken)
    );

    btb u_btb (
        .clk,
        .rst_n,
        .lookup_pc    (req.pc),
        .hit          (btb_hit),
        .target       (btb_target),
        .alloc        (upd.op == op_alloc),
        .alloc_pc     (upd.pc),
        .alloc_target (upd.target)
    );

    // history advances at resolve time only.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            history <= '0;
        end else if (upd.op != op_none) begin
            history <= {upd.taken, history[history_bits-1:1]};
        end
    end

    always_comb begin
        pred_next.valid = req.valid;
        pred_next.pc = req.pc;
        pred_next.hit = btb_hit;
        // no target without a btb hit.
        pred_next.taken = btb_hit & counter[1];
        pred_next.target = btb_target;
        pred_next.counter = counter;
        pred_next.history = history;
    end

    always_ff @(posedge clk) begin
        pred <= pred_next;
        if (!rst_n) begin
            pred.valid <= 1'b0;
        end
    end

endmodule : branch

// ==== logic/update_stage.sv ====
`timescale 1ns/1ps

module update_stage
    import bpred_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,

    input  resolve_t      resolve,
    output table_update_t upd
);

    table_update_t upd_next;

    // taken branches also claim a btb entry.
    always_comb begin
        upd_next.op = op_none;
        if (resolve.valid) begin
            upd_next.op = resolve.taken ? op_alloc : op_train;
        end
        upd_next.pc = resolve.pc;
        upd_next.taken = resolve.taken;
        upd_next.target = resolve.target;
        upd_next.history = resolve.history;
    end

    always_ff @(posedge clk) begin
        upd <= upd_next;
        if (!rst_n) begin
            upd.op <= op_none;
        end
    end

endmodule : update_stage

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit
    import bpred_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  lookup_req_t req,
    input  resolve_t    resolve,

    output prediction_t pred
);

    // registered resolve, written into the tables one cycle later.
    table_update_t upd;

    update_stage u_update_stage (
        .clk,
        .rst_n,
        .resolve,
        .upd
    );

    branch u_branch (
        .clk,
        .rst_n,
        .req,
        .upd,
        .pred
    );

endmodule : branch_unit

// ==== testbench/branch_unit_asserts.sv ====
`timescale 1ns/1ps

module branch_unit_asserts
    import bpred_pkg::*;
(
    input logic          clk,
    input logic          rst_n,
    input lookup_req_t   req,
    input table_update_t upd,
    input prediction_t   pred
);

    // one cycle lookup latency.
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> (pred.valid == $past(req.valid)))
        else $error("pred.valid does not follow req.valid by one cycle");

    // upd is cleared by the first reset edge.
    assert property (@(posedge clk) (!rst_n && $past(!rst_n)) |-> (upd.op == op_none))
        else $error("update op active during reset");

    assert property (@(posedge clk) disable iff (!rst_n) pred.taken |-> pred.hit)
        else $error("taken prediction without a btb hit");

endmodule : branch_unit_asserts

bind branch_unit branch_unit_asserts u_asserts (
    .clk,
    .rst_n,
    .req,
    .upd,
    .pred
);

// ==== testbench/tb_branch_unit.sv ====
`timescale 1ns/1ps

module tb_branch_unit
    import lc3b_types::*;
    import bpred_pkg::*;
();

    localparam int period = 100;
    localparam int random_cycles = 400;
    // six resets, the directed tests and the random run.
    localparam int test_cycles = 6 * 10 + 60 + random_cycles;

    logic        clk;
    logic        rst_n;
    lookup_req_t req;
    resolve_t    resolve;
    prediction_t pred;

    // reference model state.
    logic [history_bits-1:0] m_hist;
    ctr_t                    m_ctr [bht_entries];
    logic                    m_val [btb_sets][btb_ways];
    lc3b_word                m_tag [btb_sets][btb_ways];
    lc3b_word                m_tgt [btb_sets][btb_ways];
    logic [btb_way_bits-1:0] m_rr  [btb_sets];
    resolve_t                m_pend;

    int errors;
    int checks;
    int tests;

    branch_unit u_dut (
        .clk,
        .rst_n,
        .req,
        .resolve,
        .pred
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #((test_cycles + 50) * period);
        $display("timeout: run did not finish within %0d cycles", test_cycles + 50);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_pred(input prediction_t got, input prediction_t exp);
        checks++;
        if (got.valid !== exp.valid || (exp.valid && (got.pc !== exp.pc || got.hit !== exp.hit
                || got.taken !== exp.taken || (exp.hit && got.target !== exp.target)))) begin
            errors++;
            $display("Error %0t ns: pred pc %h got v%0b h%0b t%0b %h, exp v%0b h%0b t%0b %h",
                $time, exp.pc, got.valid, got.hit, got.taken, got.target,
                exp.valid, exp.hit, exp.taken, exp.target);
        end
    endtask

    task automatic check_counter(input ctr_t got, input ctr_t exp, input lc3b_word pc);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t ns: counter for pc %h got %s, exp %s",
                $time, pc, got.name(), exp.name());
        end
    endtask

    task automatic check_history(input logic [history_bits-1:0] got,
                                 input logic [history_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error %0t ns: history got %b, exp %b", $time, got, exp);
        end
    endtask

    task automatic model_reset();
        m_hist = '0;
        m_pend = '0;
        for (int i = 0; i < bht_entries; i++) begin
            m_ctr[i] = weak_nt;
        end
        for (int s = 0; s < btb_sets; s++) begin
            m_rr[s] = '0;
            for (int w = 0; w < btb_ways; w++) begin
                m_val[s][w] = 1'b0;
            end
        end
    endtask

    task automatic model_resolve(input resolve_t r);
        logic [bht_index_bits-1:0] idx;
        logic [btb_set_bits-1:0]   set;
        int                        way;
        if (!r.valid) return;
        idx = {r.history, r.pc[bht_pc_hi:bht_pc_lo]};
        if (r.taken && m_ctr[idx] != strong_t) begin
            m_ctr[idx] = ctr_t'(m_ctr[idx] + 2'd1);
        end else if (!r.taken && m_ctr[idx] != strong_nt) begin
            m_ctr[idx] = ctr_t'(m_ctr[idx] - 2'd1);
        end
        if (r.taken) begin
            set = r.pc[btb_index_hi:btb_index_lo];
            way = -1;
            for (int w = 0; w < btb_ways; w++) begin
                if (m_val[set][w] && m_tag[set][w] == r.pc) way = w;
            end
            for (int w = 0; w < btb_ways; w++) begin
                if (way < 0 && !m_val[set][w]) way = w;
            end
            if (way < 0) begin
                way = int'(m_rr[set]);
                m_rr[set] = m_rr[set] + 1'b1;
            end
            m_val[set][way] = 1'b1;
            m_tag[set][way] = r.pc;
            m_tgt[set][way] = r.target;
        end
        m_hist = {r.taken, m_hist[history_bits-1:1]};
    endtask

    task automatic model_predict(input lookup_req_t r, output prediction_t p);
        logic [btb_set_bits-1:0] set;
        set = r.pc[btb_index_hi:btb_index_lo];
        p = '0;
        p.valid = r.valid;
        p.pc = r.pc;
        p.counter = m_ctr[{m_hist, r.pc[bht_pc_hi:bht_pc_lo]}];
        p.history = m_hist;
        for (int w = 0; w < btb_ways; w++) begin
            if (m_val[set][w] && m_tag[set][w] == r.pc) begin
                p.hit = 1'b1;
                p.target = m_tgt[set][w];
            end
        end
        p.taken = p.hit && p.counter[1];
    endtask

    // drive one cycle, then check the prediction registered at its edge.
    task automatic run_cycle(input lookup_req_t r, input resolve_t s);
        prediction_t exp;
        req = r;
        resolve = s;
        @(posedge clk);
        model_predict(r, exp);
        model_resolve(m_pend);
        m_pend = s;
        #1;
        check_pred(pred, exp);
        if (exp.valid) begin
            check_counter(pred.counter, exp.counter, r.pc);
            check_history(pred.history, exp.history);
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        req = '0;
        resolve = '0;
        repeat (10) @(posedge clk);
        model_reset();
        #1;
        rst_n = 1'b1;
    endtask

    task automatic report_test(input string name, input int first);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - first);
    endtask

    function automatic lookup_req_t make_lookup(input lc3b_word pc);
        return {1'b1, pc};
    endfunction

    function automatic resolve_t make_resolve(input lc3b_word pc, input logic taken,
                                              input lc3b_word tgt,
                                              input logic [history_bits-1:0] h);
        return {1'b1, pc, taken, tgt, h};
    endfunction

    // 24 even pcs over four sets.
    function automatic lc3b_word random_pc();
        return 16'h3000 + lc3b_word'(($urandom % 24) * 8);
    endfunction

    initial begin
        int          first;
        lookup_req_t rq;
        resolve_t    rs;
        void'($urandom(32'h8bbd493f));
        errors = 0;
        checks = 0;
        tests = 0;

        apply_reset();
        first = errors;
        for (int i = 0; i < 8; i++) begin
            run_cycle(make_lookup(random_pc()), '0);
            check_counter(pred.counter, weak_nt, pred.pc);
            check_history(pred.history, 2'b00);
        end
        report_test("reset state", first);

        apply_reset();
        first = errors;
        run_cycle('0, make_resolve(16'h3024, 1'b1, 16'h4100, 2'b10));
        run_cycle(make_lookup(16'h3024), '0);
        run_cycle(make_lookup(16'h3024), '0);
        check_counter(pred.counter, weak_t, 16'h3024);
        repeat (3) run_cycle('0, make_resolve(16'h3024, 1'b1, 16'h4100, 2'b11));
        run_cycle('0, '0);
        run_cycle(make_lookup(16'h3024), '0);
        check_counter(pred.counter, strong_t, 16'h3024);
        check_history(pred.history, 2'b11);
        report_test("taken allocate", first);

        apply_reset();
        first = errors;
        run_cycle('0, make_resolve(16'h3024, 1'b1, 16'h4100, 2'b00));
        repeat (3) run_cycle('0, make_resolve(16'h3024, 1'b0, 16'h4100, 2'b00));
        run_cycle('0, make_resolve(16'h3048, 1'b0, 16'h4200, 2'b00));
        run_cycle('0, '0);
        run_cycle(make_lookup(16'h3024), '0);
        check_counter(pred.counter, strong_nt, 16'h3024);
        check_history(pred.history, 2'b00);
        run_cycle(make_lookup(16'h3048), '0);
        report_test("not-taken train", first);

        apply_reset();
        first = errors;
        repeat (16) begin
            run_cycle(make_lookup(16'h3024),
                      make_resolve(16'h3024, 1'($urandom % 2), 16'h4300, m_hist));
        end
        report_test("history", first);

        apply_reset();
        first = errors;
        for (int i = 0; i < 5; i++) begin
            run_cycle('0, make_resolve(16'h3000 + lc3b_word'(i * 32), 1'b1,
                                       16'h5000 + lc3b_word'(i * 4), 2'b00));
        end
        // way 2 is away from the round-robin pointer.
        run_cycle('0, make_resolve(16'h3040, 1'b1, 16'h5f00, 2'b00));
        run_cycle('0, '0);
        for (int i = 0; i < 5; i++) begin
            run_cycle(make_lookup(16'h3000 + lc3b_word'(i * 32)), '0);
        end
        report_test("btb replacement", first);

        apply_reset();
        first = errors;
        repeat (random_cycles) begin
            rq = make_lookup(random_pc());
            rq.valid = 1'($urandom % 2);
            rs = make_resolve(random_pc(), 1'($urandom % 2),
                              lc3b_word'($urandom) & 16'hfffe, 2'($urandom % 4));
            rs.valid = 1'($urandom % 2);
            run_cycle(rq, rs);
        end
        report_test("random mix", first);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_branch_unit

// ==== branch_unit.f ====
logic/lc3b_types.sv
logic/bpred_pkg.sv
logic/bht.sv
logic/btb.sv
logic/branch.sv
logic/update_stage.sv
logic/branch_unit.sv
testbench/branch_unit_asserts.sv
testbench/tb_branch_unit.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := tb_branch_unit
FILELIST  := branch_unit.f
FLAGS     := --timing --assert
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
